/* quad_pkg.sv */
// shared opcodes, widths, ESC timing and the command data union, imported by every flight-control block
package quad_pkg;

    // command opcodes, first byte of each frame
    localparam logic [7:0] OP_SET_PTCH  = 8'h02;
    localparam logic [7:0] OP_SET_ROLL  = 8'h03;
    localparam logic [7:0] OP_SET_YAW   = 8'h04;
    localparam logic [7:0] OP_SET_THRST = 8'h05;
    localparam logic [7:0] OP_CALIBRATE = 8'h06;
    localparam logic [7:0] OP_EMER_LAND = 8'h07;  // unknown opcodes land too
    localparam logic [7:0] OP_MTRS_OFF  = 8'h08;

    localparam logic [7:0] RESP_ACK = 8'hA5;  // positive acknowledge byte

    // datapath widths
    localparam int DATA_W    = 16;  // data word from hi and lo bytes
    localparam int THRST_W   = 9;
    localparam int SPD_W     = 9;   // motor speed 0..511
    localparam int MIX_SHIFT = 4;   // angle scaling ahead of the mixer

    // calibration ramp timer, 512 cycles in RAMP_MOTORS
    localparam int CAL_WAIT_W = 9;

    // ESC pulse timing
    localparam int ESC_PER_W  = 10;  // 1024 cycle frame
    localparam int ESC_MIN_HI = 64;  // pulse width at zero speed

    localparam int N_MOTORS = 4;  // front, back, left, right

    // thrust view of the data word
    typedef struct packed {
        logic [DATA_W-THRST_W-1:0] unused;  // upper bits ignored
        logic [THRST_W-1:0]        val;
    } thrust_t;

    // one data word, read as a signed angle or as thrust
    typedef union packed {
        logic signed [DATA_W-1:0] angle;  // pitch, roll, yaw
        thrust_t                  thrust;
    } cmd_data_u;

endpackage

/* cmd_assemble.sv */
// groups strobed receive bytes into opcode plus 16-bit data frames and holds cmd_rdy for the decoder
`timescale 1ns/1ps

module cmd_assemble (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rx_vld,      // one byte per strobe
    input  logic [7:0]          rx_byte,
    input  logic                clr_cmd_rdy, // decoder has taken the frame
    output logic [7:0]          cmd,
    output quad_pkg::cmd_data_u data,
    output logic                cmd_rdy
);

    import quad_pkg::*;

    logic [1:0] byte_cnt;  // 0 opcode, 1 data hi, 2 data lo
    logic [7:0] data_hi;
    logic [7:0] data_lo;
    logic       take_byte; // byte accepted this cycle

    // bytes are dropped while a frame is still pending
    assign take_byte = rx_vld && !cmd_rdy;

    // byte counter and ready flag
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            cmd_rdy  <= 1'b0;
        end else if (clr_cmd_rdy) begin
            cmd_rdy <= 1'b0;  // counter already back at 0
        end else if (take_byte) begin
            if (byte_cnt == 2'd2) begin
                byte_cnt <= '0;
                cmd_rdy  <= 1'b1;  // rises with the third byte
            end else begin
                byte_cnt <= byte_cnt + 2'd1;
            end
        end
    end

    // capture registers for the opcode and the two data bytes
    always_ff @(posedge clk) begin
        if (take_byte) begin
            case (byte_cnt)
                2'd0:    cmd     <= rx_byte;
                2'd1:    data_hi <= rx_byte;
                2'd2:    data_lo <= rx_byte;
                default: ;  // counter never reaches 3
            endcase
        end
    end

    // high byte first on the wire
    assign data = cmd_data_u'({data_hi, data_lo});

    // the decoder may only clear a frame that is actually pending
    a_clr_only_when_rdy : assert property (
        @(posedge clk) disable iff (!rst_n) clr_cmd_rdy |-> cmd_rdy
    ) else $error("clr_cmd_rdy seen with no pending frame");

endmodule

/* cmd_cfg.sv */
// command decoder FSM holding desired attitude and thrust, running calibration and sending acks
`timescale 1ns/1ps

module cmd_cfg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cmd_rdy,      // frame pending from the assembler
    input  logic [7:0]                   cmd,
    input  quad_pkg::cmd_data_u          data,
    input  logic                         cal_done,     // strobe from integrator
    output logic                         clr_cmd_rdy,
    output logic [7:0]                   resp,
    output logic                         send_resp,
    output quad_pkg::cmd_data_u          d_ptch,
    output quad_pkg::cmd_data_u          d_roll,
    output quad_pkg::cmd_data_u          d_yaw,
    output logic [quad_pkg::THRST_W-1:0] thrst,
    output logic                         strt_cal,     // one registered cycle
    output logic                         inertial_cal, // level during calibration
    output logic                         motors_off
);

    import quad_pkg::*;

    typedef enum logic [1:0] {IDLE, RAMP_MOTORS, CAL} state_t;

    state_t state;
    state_t nxt_state;

    logic wr_ptch;       // load strobes for the holding registers
    logic wr_roll;
    logic wr_yaw;
    logic wr_thrst;
    logic emer_land;     // zero all four
    logic set_mtrs_off;
    logic ack;           // acknowledge and clear the frame
    logic go_cal;        // CALIBRATE taken so clear without response
    logic cal_resp;      // response at end of calibration
    logic clr_tmr;
    logic strt_cal_nxt;

    logic [CAL_WAIT_W-1:0] cal_tmr;
    logic                  tmr_full;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= nxt_state;
    end

    // next state and decode
    always_comb begin
        nxt_state    = state;
        wr_ptch      = 1'b0;
        wr_roll      = 1'b0;
        wr_yaw       = 1'b0;
        wr_thrst     = 1'b0;
        emer_land    = 1'b0;
        set_mtrs_off = 1'b0;
        ack          = 1'b0;
        go_cal       = 1'b0;
        cal_resp     = 1'b0;
        clr_tmr      = 1'b1;
        strt_cal_nxt = 1'b0;
        inertial_cal = 1'b0;
        case (state)
            RAMP_MOTORS: begin  // let the motors spin up before calibrating
                clr_tmr      = 1'b0;
                inertial_cal = 1'b1;
                if (tmr_full) begin
                    strt_cal_nxt = 1'b1;
                    nxt_state    = CAL;
                end
            end
            CAL: begin  // no timeout since the integrator decides
                if (cal_done) begin
                    cal_resp  = 1'b1;  // inertial_cal drops this cycle
                    nxt_state = IDLE;
                end else begin
                    inertial_cal = 1'b1;
                end
            end
            default: begin  // IDLE is the only state that reads commands
                if (cmd_rdy) begin
                    case (cmd)
                        OP_SET_PTCH:  wr_ptch  = 1'b1;
                        OP_SET_ROLL:  wr_roll  = 1'b1;
                        OP_SET_YAW:   wr_yaw   = 1'b1;
                        OP_SET_THRST: wr_thrst = 1'b1;
                        OP_MTRS_OFF:  set_mtrs_off = 1'b1;
                        OP_CALIBRATE: begin
                            go_cal       = 1'b1;
                            inertial_cal = 1'b1;  // up from the clear cycle
                            nxt_state    = RAMP_MOTORS;
                        end
                        default: emer_land = 1'b1;  // OP_EMER_LAND or garbage
                    endcase
                    ack = !go_cal;
                end
            end
        endcase
    end

    assign clr_cmd_rdy = ack | go_cal;
    assign send_resp   = ack | cal_resp;
    assign resp        = send_resp ? RESP_ACK : 8'h00;

    // holding registers
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            d_ptch <= '0;
            d_roll <= '0;
            d_yaw  <= '0;
            thrst  <= '0;
        end else if (emer_land) begin
            d_ptch <= '0;
            d_roll <= '0;
            d_yaw  <= '0;
            thrst  <= '0;
        end else begin
            if (wr_ptch)  d_ptch <= data;
            if (wr_roll)  d_roll <= data;
            if (wr_yaw)   d_yaw  <= data;
            if (wr_thrst) thrst  <= data.thrust.val;  // low 9 bits only
        end
    end

    // ramp timer held at zero outside RAMP_MOTORS
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            cal_tmr <= '0;
        else if (clr_tmr)
            cal_tmr <= '0;
        else
            cal_tmr <= cal_tmr + 1'b1;
    end

    assign tmr_full = &cal_tmr;

    // registered so strt_cal is glitch free
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            strt_cal <= 1'b0;
        else
            strt_cal <= strt_cal_nxt;
    end

    // motors off until a calibration is started
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            motors_off <= 1'b1;
        else if (set_mtrs_off)
            motors_off <= 1'b1;
        else if (go_cal)
            motors_off <= 1'b0;
    end

    a_strt_cal_single : assert property (
        @(posedge clk) disable iff (!rst_n) strt_cal |=> !strt_cal
    ) else $error("strt_cal high on two consecutive cycles");

endmodule

/* motor_mix.sv */
// open-loop mixer turning desired thrust, pitch, roll and yaw into four saturated motor speeds
`timescale 1ns/1ps

module motor_mix (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  quad_pkg::cmd_data_u                              d_ptch,
    input  quad_pkg::cmd_data_u                              d_roll,
    input  quad_pkg::cmd_data_u                              d_yaw,
    input  logic [quad_pkg::THRST_W-1:0]                     thrst,
    input  logic                                             motors_off,
    output logic [quad_pkg::N_MOTORS-1:0][quad_pkg::SPD_W-1:0] spd  // 0 front 1 back 2 left 3 right
);

    import quad_pkg::*;

    logic signed [DATA_W-1:0] ptch_s;  // angles after scaling
    logic signed [DATA_W-1:0] roll_s;
    logic signed [DATA_W-1:0] yaw_s;
    logic signed [DATA_W-1:0] thr_s;   // thrust zero extended
    logic signed [DATA_W-1:0] mix [N_MOTORS];

    // clamp a signed mix into 0..511
    function automatic logic [SPD_W-1:0] sat_spd(input logic signed [DATA_W-1:0] val);
        if (val < 0)
            return '0;
        else if (|val[DATA_W-1:SPD_W])
            return '1;  // above 511
        else
            return val[SPD_W-1:0];
    endfunction

    assign ptch_s = $signed(d_ptch.angle) >>> MIX_SHIFT;
    assign roll_s = $signed(d_roll.angle) >>> MIX_SHIFT;
    assign yaw_s  = $signed(d_yaw.angle) >>> MIX_SHIFT;
    assign thr_s  = {{(DATA_W-THRST_W){1'b0}}, thrst};

    // worst case stays well inside DATA_W bits
    assign mix[0] = thr_s + ptch_s - yaw_s;  // front
    assign mix[1] = thr_s - ptch_s - yaw_s;  // back
    assign mix[2] = thr_s + roll_s + yaw_s;  // left
    assign mix[3] = thr_s - roll_s + yaw_s;  // right

    // one register stage, motors_off overrides everything
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            spd <= '0;
        end else begin
            for (int i = 0; i < N_MOTORS; i++)
                spd[i] <= motors_off ? '0 : sat_spd(mix[i]);
        end
    end

endmodule

/* esc_pwm.sv */
// single-motor ESC pulse generator, pulse of ESC_MIN_HI plus speed each 1024-cycle frame
`timescale 1ns/1ps

module esc_pwm (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [quad_pkg::SPD_W-1:0] spd,
    output logic                       esc
);

    import quad_pkg::*;

    logic [ESC_PER_W-1:0] per_cnt;  // free running frame counter
    logic [ESC_PER_W-1:0] hi_w;     // pulse width for the current frame

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            per_cnt <= '0;
        else
            per_cnt <= per_cnt + 1'b1;  // wraps every 1024
    end

    // new speed only taken at frame start so a pulse is never cut short
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            hi_w <= ESC_PER_W'(ESC_MIN_HI);  // minimum pulse out of reset
        else if (per_cnt == '0)
            hi_w <= ESC_PER_W'(ESC_MIN_HI) + ESC_PER_W'(spd);
    end

    assign esc = (per_cnt < hi_w);  // max width 575, always under the frame

    a_esc_high_at_start : assert property (
        @(posedge clk) disable iff (!rst_n) (per_cnt == '0) |-> esc
    ) else $error("ESC line low at frame start");

endmodule

/* quad_ctrl_top.sv */
// top level of the command side, assembler to decoder to mixer to four ESC generators
`timescale 1ns/1ps

module quad_ctrl_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rx_vld,
    input  logic [7:0]                    rx_byte,
    input  logic                          cal_done,
    output logic [7:0]                    resp,
    output logic                          send_resp,
    output logic                          strt_cal,
    output logic                          inertial_cal,
    output logic                          motors_off,
    output logic [quad_pkg::N_MOTORS-1:0] esc  // front, back, left, right
);

    import quad_pkg::*;

    logic [7:0]         cmd;
    cmd_data_u          data;
    logic               cmd_rdy;
    logic               clr_cmd_rdy;
    cmd_data_u          d_ptch;
    cmd_data_u          d_roll;
    cmd_data_u          d_yaw;
    logic [THRST_W-1:0] thrst;

    logic [N_MOTORS-1:0][SPD_W-1:0] spd;  // one slice per ESC

    cmd_assemble u_asm (
        .clk, .rst_n, .rx_vld, .rx_byte, .clr_cmd_rdy,
        .cmd, .data, .cmd_rdy
    );

    cmd_cfg u_cfg (
        .clk, .rst_n, .cmd_rdy, .cmd, .data, .cal_done,
        .clr_cmd_rdy, .resp, .send_resp,
        .d_ptch, .d_roll, .d_yaw, .thrst,
        .strt_cal, .inertial_cal, .motors_off
    );

    motor_mix u_mix (
        .clk, .rst_n, .d_ptch, .d_roll, .d_yaw, .thrst, .motors_off,
        .spd
    );

    // one pulse generator per motor
    for (genvar i = 0; i < N_MOTORS; i++) begin : g_esc
        esc_pwm u_esc (
            .clk   (clk),
            .rst_n (rst_n),
            .spd   (spd[i]),
            .esc   (esc[i])
        );
    end

endmodule

/* quad_ctrl_top_tb.sv */
// self-checking testbench for quad_ctrl_top, plays a command table and measures the ESC pulse widths
`timescale 1ns/1ps

module quad_ctrl_top_tb;

    import quad_pkg::*;

    localparam int MAX_CMD = 16;
    localparam int FRAME   = 1 << ESC_PER_W;  // ESC frame in cycles

    logic       clk;
    logic       rst_n;
    logic       rx_vld;
    logic [7:0] rx_byte;
    logic       cal_done;
    logic [7:0] resp;
    logic       send_resp;
    logic       strt_cal;
    logic       inertial_cal;
    logic       motors_off;
    logic [3:0] esc;

    // command table, expected speeds come from the reference model in add_cmd
    logic [7:0]  tbl_op   [MAX_CMD];
    logic [15:0] tbl_data [MAX_CMD];
    bit          tbl_resp [MAX_CMD];  // ack in the cycle after the third byte
    bit          tbl_off  [MAX_CMD];  // motors_off after the command
    int          tbl_spd  [MAX_CMD][N_MOTORS];
    int          n_cmd;

    // reference copy of the holding registers
    int m_ptch;
    int m_roll;
    int m_yaw;
    int m_thr;
    bit m_off;

    int         n_err;
    int         n_tmo;
    int         resp_cnt = 0;  // every send_resp pulse seen
    int         hi_cnt [N_MOTORS];
    logic [7:0] lfsr;

    quad_ctrl_top DUT (
        .clk, .rst_n, .rx_vld, .rx_byte, .cal_done,
        .resp, .send_resp, .strt_cal, .inertial_cal, .motors_off, .esc
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(negedge clk)
        if (rst_n && send_resp)
            resp_cnt++;

    // galois LFSR, one step per bit taken
    function automatic bit next_bit();
        bit b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 8'hB8;
        return b;
    endfunction

    function automatic int rand_gap();  // 0..3 idle cycles
        int g;
        g = next_bit();
        g = 2 * g + next_bit();
        return g;
    endfunction

    function automatic int clamp_spd(input int v);
        if (v < 0)
            return 0;
        else if (v > 511)
            return 511;
        else
            return v;
    endfunction

    // append one command and work out the speeds it should leave behind
    task automatic add_cmd(input logic [7:0] op, input logic [15:0] d);
        int p;
        int r;
        int y;
        case (op)
            OP_SET_PTCH:  m_ptch = int'($signed(d));
            OP_SET_ROLL:  m_roll = int'($signed(d));
            OP_SET_YAW:   m_yaw  = int'($signed(d));
            OP_SET_THRST: m_thr  = int'(d[8:0]);  // upper bits ignored
            OP_CALIBRATE: m_off  = 1'b0;
            OP_MTRS_OFF:  m_off  = 1'b1;
            default: begin  // land, also for unknown opcodes
                m_ptch = 0;
                m_roll = 0;
                m_yaw  = 0;
                m_thr  = 0;
            end
        endcase
        p = m_ptch >>> MIX_SHIFT;
        r = m_roll >>> MIX_SHIFT;
        y = m_yaw >>> MIX_SHIFT;
        tbl_op[n_cmd]     = op;
        tbl_data[n_cmd]   = d;
        tbl_resp[n_cmd]   = (op != OP_CALIBRATE);
        tbl_off[n_cmd]    = m_off;
        tbl_spd[n_cmd][0] = m_off ? 0 : clamp_spd(m_thr + p - y);  // front
        tbl_spd[n_cmd][1] = m_off ? 0 : clamp_spd(m_thr - p - y);  // back
        tbl_spd[n_cmd][2] = m_off ? 0 : clamp_spd(m_thr + r + y);  // left
        tbl_spd[n_cmd][3] = m_off ? 0 : clamp_spd(m_thr - r + y);  // right
        n_cmd++;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            n_err++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_tmo++;
        $display("Timeout at %0t ns: %s", $time, what);
    endtask

    // opcode, data hi, data lo with random idle gaps in between
    task automatic send_frame(input logic [7:0] op, input logic [15:0] d);
        logic [7:0] bytes [3];
        int         gap;
        bytes[0] = op;
        bytes[1] = d[15:8];
        bytes[2] = d[7:0];
        @(posedge clk);
        #2;
        for (int b = 0; b < 3; b++) begin
            rx_vld  = 1'b1;
            rx_byte = bytes[b];
            @(posedge clk);  // byte captured here
            #2;
            rx_vld = 1'b0;
            if (b < 2) begin
                gap = rand_gap();
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                end
            end
        end
    endtask

    // called at the negedge of the clear cycle
    task automatic run_calibration();
        int cyc;
        bit seen;
        check_val("inertial_cal", inertial_cal, 1);
        cyc  = 0;
        seen = 0;
        while (!seen && cyc < 1000) begin
            @(negedge clk);
            cyc++;
            seen = strt_cal;
        end
        if (!seen) begin
            report_timeout("no strt_cal pulse within 1000 cycles of CALIBRATE");
        end else begin
            if (cyc < 512) begin
                n_err++;
                $display("strt_cal came only %0d cycles after CALIBRATE", cyc);
            end
            @(negedge clk);
            check_val("strt_cal", strt_cal, 0);  // single pulse
            check_val("inertial_cal", inertial_cal, 1);
        end
        repeat (20) @(posedge clk);  // integrator takes a while
        #2;
        cal_done = 1'b1;
        @(negedge clk);
        check_val("send_resp", send_resp, 1);
        check_val("resp", resp, RESP_ACK);
        check_val("inertial_cal", inertial_cal, 0);  // drops in the cal_done cycle
        @(posedge clk);
        #2;
        cal_done = 1'b0;
    endtask

    // sync to a fresh frame on esc[0], then count high cycles over two frames
    task automatic measure_widths();
        int   cyc;
        logic prev;
        bit   found;
        repeat (3) @(posedge clk);  // holding regs then mixer register
        cyc   = 0;
        found = 0;
        @(negedge clk);
        prev = esc[0];
        while (!found && cyc < FRAME + 64) begin
            @(negedge clk);
            cyc++;
            found = esc[0] && !prev;
            prev  = esc[0];
        end
        for (int m = 0; m < N_MOTORS; m++)
            hi_cnt[m] = 0;
        if (!found) begin
            report_timeout("no ESC frame start seen on esc[0]");
        end else begin
            for (int c = 0; c < 2 * FRAME; c++) begin
                for (int m = 0; m < N_MOTORS; m++)
                    if (esc[m])
                        hi_cnt[m]++;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        int start_cnt;
        clk      = 1'b0;
        rst_n    = 1'b0;
        rx_vld   = 1'b0;
        rx_byte  = 8'h00;
        cal_done = 1'b0;
        lfsr     = 8'd72;
        n_err    = 0;
        n_tmo    = 0;
        n_cmd    = 0;
        m_ptch   = 0;
        m_roll   = 0;
        m_yaw    = 0;
        m_thr    = 0;
        m_off    = 1'b1;  // motors off out of reset

        add_cmd(OP_SET_THRST, 16'h0100);  // no effect yet, motors off
        add_cmd(OP_CALIBRATE, 16'h0000);
        add_cmd(OP_SET_PTCH,  16'h0320);  // +50 after scaling
        add_cmd(OP_SET_ROLL,  16'hFF60);  // -10
        add_cmd(OP_SET_YAW,   16'h00A0);  // +10
        add_cmd(OP_SET_THRST, 16'h01F0);  // front and right clamp at 511
        add_cmd(OP_SET_THRST, 16'h0010);  // back clamps at 0
        add_cmd(OP_EMER_LAND, 16'h0000);
        add_cmd(OP_SET_THRST, 16'h00C8);
        add_cmd(8'h3C,        16'h1234);  // unknown opcode lands
        add_cmd(OP_SET_THRST, 16'hFE80);  // only the low 9 bits count
        add_cmd(OP_MTRS_OFF,  16'h0000);
        add_cmd(OP_SET_PTCH,  16'h8000);  // ignored while off

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_val("motors_off", motors_off, 1);
        check_val("strt_cal", strt_cal, 0);
        check_val("inertial_cal", inertial_cal, 0);
        measure_widths();
        for (int m = 0; m < N_MOTORS; m++)
            check_val($sformatf("esc[%0d] high cycles", m), hi_cnt[m], 2 * ESC_MIN_HI);

        for (int i = 0; i < n_cmd; i++) begin
            start_cnt = resp_cnt;
            send_frame(tbl_op[i], tbl_data[i]);
            @(negedge clk);  // cycle after the third byte
            check_val("send_resp", send_resp, tbl_resp[i]);
            if (tbl_resp[i])
                check_val("resp", resp, RESP_ACK);
            if (tbl_op[i] == OP_CALIBRATE)
                run_calibration();
            measure_widths();
            for (int m = 0; m < N_MOTORS; m++)
                check_val($sformatf("esc[%0d] high cycles", m), hi_cnt[m],
                          2 * (ESC_MIN_HI + tbl_spd[i][m]));
            check_val("motors_off", motors_off, tbl_off[i]);
            check_val("send_resp count", resp_cnt - start_cnt, 1);
        end

        $display("errors: %0d value mismatches, %0d timeouts", n_err, n_tmo);
        if (n_err == 0 && n_tmo == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* quad_ctrl_top.f */
quad_pkg.sv
cmd_assemble.sv
cmd_cfg.sv
motor_mix.sv
esc_pwm.sv
quad_ctrl_top.sv
quad_ctrl_top_tb.sv

/* Bender.yml */
package:
  name: quad_ctrl

sources:
  - files:
      - quad_pkg.sv
      - cmd_assemble.sv
      - cmd_cfg.sv
      - motor_mix.sv
      - esc_pwm.sv
      - quad_ctrl_top.sv
  - target: test
    files:
      - quad_ctrl_top_tb.sv
